/* verilog.f */
hw/sw_cfg_pkg.sv
hw/sw_pkt_pkg.sv
hw/sw_word_if.sv
hw/port_hdr_parse.sv
hw/port_pkt_buffer.sv
hw/port_desc_queue.sv
hw/port_ctrl.sv
hw/port_top.sv
bench/tb_port.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0 -Wno-fatal
TOP       := tb_port
FILELIST  := verilog.f
BUILD     := obj_dir
BIN       := $(BUILD)/V$(TOP)
LOG       := sim.log
GOLDEN    := bench/port_golden.txt
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN) $(GOLDEN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/port_golden.txt */
// dest prio hdr_len count hold stop outcome
// stop is a hex xfer_stop mask walked one bit per stream cycle, hold keeps ack low
3 1 8 8 0 00 pass
5 7 1 1 0 00 pass
2 2 0 3 0 00 drop
9 4 70 70 0 00 drop
1 0 65 4 0 00 drop
6 3 10 7 0 00 drop
6 3 10 10 0 00 pass
7 5 5 9 0 00 drop
4 6 12 12 0 00 pass
0 1 60 60 1 00 pass
8 2 60 60 1 00 pass
10 3 60 60 1 00 drop
11 4 16 16 0 a5 pass
12 5 20 20 0 3c pass
15 7 64 64 0 92 pass
13 0 2 2 0 b6 pass
14 2 33 33 0 49 pass

/* bench/tb_port.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_port
    import sw_cfg_pkg::*, sw_pkt_pkg::*;
();

    localparam int wait_limit = 4000; // cycles allowed for any single wait

    logic              clk;
    logic              rst_n;
    logic              wr_sop;
    logic              wr_eop;
    logic              wr_vld;
    logic [word_w-1:0] wr_data;
    logic              ack;
    logic              xfer_stop;
    logic              req;
    logic [prio_w-1:0] prior;
    logic [dest_w-1:0] dest_port;
    logic [len_w-1:0]  length;
    logic [word_w-1:0] data;
    logic              writting;
    logic              unlock;
    logic              drop;

    // one entry per golden line
    int       g_dest [64];
    int       g_prio [64];
    int       g_len [64];
    int       g_cnt [64];
    int       g_hold [64];
    bit [7:0] g_stop [64];
    bit       g_pass [64];
    int       n_lines = 0;
    int       n_pass = 0;

    // packets the fabric has yet to receive, in arrival order
    logic [len_w-1:0]  len_q [$];
    logic [prio_w-1:0] prio_q [$];
    logic [dest_w-1:0] dest_q [$];
    logic [7:0]        stop_q [$];
    logic [word_w-1:0] word_q [$];

    int   pushed_pkts = 0;
    int   done_pkts = 0;
    int   drop_seen = 0;
    int   unlock_seen = 0;
    int   val_errs = 0;
    int   flow_errs = 0;
    int   timeouts = 0;
    logic hold_ack = 1'b0;
    logic req_q = 1'b0;

    port_top dut_i (.clk, .rst_n, .wr_sop, .wr_eop, .wr_vld, .wr_data, .ack, .xfer_stop,
                    .req, .prior, .dest_port, .length, .data, .writting, .unlock, .drop);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // protocol monitor

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (drop)
                drop_seen++;
            if (unlock)
            begin
                unlock_seen++;
                if (req || !req_q)
                begin
                    $display("req did not fall in the cycle of unlock");
                    flow_errs++;
                end
            end
            if (req && !req_q && ack)
            begin
                $display("req was raised while ack was still high");
                flow_errs++;
            end
            req_q <= req;
        end
    end

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] want);
        $display("ERROR %s: got 0x%h expected 0x%h", name, got, want);
        val_errs++;
    endtask

    task automatic read_golden();
        int               fd;
        int               rc;
        int               d, p, l, c, h;
        logic [7:0]       s;
        logic [8*4-1:0]   outc;
        logic [8*128-1:0] line;
        fd = $fopen("bench/port_golden.txt", "r");
        if (fd == 0)
        begin
            $display("could not open bench/port_golden.txt");
            flow_errs++;
            return;
        end
        while (!$feof(fd) && n_lines < 64)
        begin
            line = '0;
            rc = $fgets(line, fd);
            rc = $sscanf(line, "%d %d %d %d %d %h %s", d, p, l, c, h, s, outc);
            if (rc == 7) // comment and blank lines do not match
            begin
                g_dest[n_lines] = d;
                g_prio[n_lines] = p;
                g_len[n_lines] = l;
                g_cnt[n_lines] = c;
                g_hold[n_lines] = h;
                g_stop[n_lines] = s;
                g_pass[n_lines] = (outc == "pass");
                if (outc == "pass")
                    n_pass++;
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (done_pkts != pushed_pkts && t < wait_limit)
        begin
            @(negedge clk);
            t++;
        end
        if (done_pkts != pushed_pkts)
        begin
            $display("timeout while waiting for the fabric to drain earlier packets");
            timeouts++;
        end
    endtask

    ////////////////////////////////////////
    // sender

    task automatic send_line(input int i);
        logic [word_w-1:0] hdr;
        logic [word_w-1:0] w;
        int                start_drops;
        int                got;
        int                k;
        hdr = {len_w'(g_len[i]), prio_w'(g_prio[i]), dest_w'(g_dest[i])};
        // a held run starts and ends with an empty buffer so room is known
        if (g_hold[i] != 0 && !hold_ack)
            wait_drained();
        if (g_hold[i] == 0 && hold_ack)
        begin
            hold_ack = 1'b0;
            wait_drained();
        end
        hold_ack = g_hold[i] != 0;
        if (g_pass[i])
        begin
            len_q.push_back(len_w'(g_len[i]));
            prio_q.push_back(prio_w'(g_prio[i]));
            dest_q.push_back(dest_w'(g_dest[i]));
            stop_q.push_back(g_stop[i]);
            pushed_pkts++;
        end
        start_drops = drop_seen;
        @(posedge clk);
        #2;
        wr_sop = 1'b1;
        wr_eop = 1'b0;
        wr_vld = 1'b1;
        wr_data = hdr;
        for (k = 0; k < g_cnt[i]; k++)
        begin
            w = word_w'($urandom);
            if (g_pass[i])
                word_q.push_back(w);
            @(posedge clk);
            #2;
            wr_sop = 1'b0;
            wr_eop = (k == g_cnt[i] - 1);
            wr_data = w;
        end
        @(posedge clk);
        #2;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
        wr_vld = 1'b0;
        repeat (3) @(negedge clk); // drop lands one cycle after eop at the latest
        got = drop_seen - start_drops;
        if (got != (g_pass[i] ? 0 : 1))
        begin
            $display("golden line %0d expected %0d drop pulses but saw %0d", i,
                     g_pass[i] ? 0 : 1, got);
            flow_errs++;
        end
    endtask

    ////////////////////////////////////////
    // fabric

    task automatic serve_packet();
        logic [len_w-1:0]  e_len;
        logic [prio_w-1:0] e_prio;
        logic [dest_w-1:0] e_dest;
        logic [7:0]        pat;
        logic [word_w-1:0] w;
        logic [word_w-1:0] held;
        logic              stalled;
        int                t;
        int                taken;
        int                cyc;
        t = 0;
        @(negedge clk);
        while (!req && t < wait_limit)
        begin
            @(negedge clk);
            t++;
        end
        if (!req)
        begin
            $display("timeout while waiting for req");
            timeouts++;
            return;
        end
        if (len_q.size() == 0)
        begin
            $display("req was raised with no good packet outstanding");
            flow_errs++;
            return;
        end
        e_len = len_q.pop_front();
        e_prio = prio_q.pop_front();
        e_dest = dest_q.pop_front();
        pat = stop_q.pop_front();
        if (length !== e_len)
            report_mismatch("length", 16'(length), 16'(e_len));
        if (prior !== e_prio)
            report_mismatch("prior", 16'(prior), 16'(e_prio));
        if (dest_port !== e_dest)
            report_mismatch("dest_port", 16'(dest_port), 16'(e_dest));
        t = 0;
        while (hold_ack && t < wait_limit)
        begin
            @(negedge clk);
            t++;
        end
        if (hold_ack)
        begin
            $display("timeout while ack was held back");
            timeouts++;
        end
        repeat (1 + $urandom % 3) @(posedge clk);
        #2;
        ack = 1'b1;
        xfer_stop = pat[0];
        taken = 0;
        cyc = 0;
        stalled = 1'b0;
        held = '0;
        while (taken < int'(e_len) && cyc < wait_limit)
        begin
            @(negedge clk);
            if (writting)
            begin
                if (stalled && data !== held)
                    report_mismatch("data while stalled", data, held);
                if (!xfer_stop)
                begin
                    if (word_q.size() == 0)
                    begin
                        $display("fabric took a word that was never sent");
                        flow_errs++;
                    end
                    else
                    begin
                        w = word_q.pop_front();
                        if (data !== w)
                            report_mismatch("data", data, w);
                    end
                    taken++;
                end
                stalled = xfer_stop;
                held = data;
            end
            else
                stalled = 1'b0;
            cyc++;
            if (taken < int'(e_len))
            begin
                @(posedge clk);
                #2;
                xfer_stop = pat[3'(cyc)];
            end
        end
        if (taken < int'(e_len))
        begin
            $display("timeout while streaming, %0d of %0d words taken", taken, e_len);
            timeouts++;
        end
        t = 0;
        @(negedge clk);
        while (!unlock && t < 20)
        begin
            @(negedge clk);
            t++;
        end
        if (!unlock)
        begin
            $display("timeout while waiting for unlock");
            timeouts++;
        end
        // ack stays high past the idle cycle so an early req would meet it
        repeat (3 + $urandom % 3) @(posedge clk);
        #2;
        ack = 1'b0;
        xfer_stop = 1'b0;
        done_pkts++;
    endtask

    initial
    begin
        int seed;
        int i;
        int j;
        rst_n = 1'b0;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
        wr_vld = 1'b0;
        wr_data = '0;
        ack = 1'b0;
        xfer_stop = 1'b0;
        seed = $urandom(32'h695d);
        read_golden();
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        fork
            begin
                for (i = 0; i < n_lines; i++)
                    send_line(i);
                hold_ack = 1'b0;
            end
            begin
                for (j = 0; j < n_pass; j++)
                    serve_packet();
            end
        join
        repeat (4) @(negedge clk);
        if (unlock_seen != n_pass)
        begin
            $display("unlock pulsed %0d times for %0d good packets", unlock_seen, n_pass);
            flow_errs++;
        end
        $display("value errors %0d, protocol errors %0d, timeouts %0d",
                 val_errs, flow_errs, timeouts);
        if (val_errs + flow_errs + timeouts == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/port_top.sv */
`timescale 1ns/1ps
`default_nettype none

module port_top
    import sw_cfg_pkg::*, sw_pkt_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_sop,
    input  logic              wr_eop,
    input  logic              wr_vld,
    input  logic [word_w-1:0] wr_data,
    input  logic              ack,
    input  logic              xfer_stop,
    output logic              req,
    output logic [prio_w-1:0] prior,
    output logic [dest_w-1:0] dest_port,
    output logic [len_w-1:0]  length,
    output logic [word_w-1:0] data,
    output logic              writting,
    output logic              unlock,
    output logic              drop
);

    logic            hdr_done;
    logic            hdr_ok;
    pkt_desc_t       hdr_desc;
    pkt_desc_t       head;
    logic            not_empty;
    logic            full;
    logic [buf_aw:0] buf_free;
    logic            wr_en, commit, rollback, rd_en, push, pop;

    sw_word_if word ();

    assign word.sop = wr_sop;
    assign word.eop = wr_eop;
    assign word.vld = wr_vld;
    assign word.data = wr_data;

    port_hdr_parse hdr_parse_i (.clk, .rst_n, .word, .buf_free, .hdr_done, .hdr_ok,
                                .desc(hdr_desc));

    port_pkt_buffer pkt_buffer_i (.clk, .rst_n, .word, .wr_en, .commit, .rollback, .rd_en,
                                  .rd_data(data), .free(buf_free));

    port_desc_queue desc_queue_i (.clk, .rst_n, .push, .push_desc(hdr_desc), .pop, .head,
                                  .not_empty, .full);

    port_ctrl ctrl_i (.clk, .rst_n, .word, .hdr_done, .hdr_ok, .head, .not_empty, .full,
                      .ack, .xfer_stop, .wr_en, .commit, .rollback, .push, .pop, .rd_en,
                      .req, .writting, .unlock, .drop);

    // the offered packet is always the queue head
    assign prior = head.prio;
    assign dest_port = head.dest;
    assign length = head.len;

endmodule

`default_nettype wire

/* hw/port_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module port_ctrl
    import sw_pkt_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    sw_word_if.snk    word,
    input  logic      hdr_done,
    input  logic      hdr_ok,
    input  pkt_desc_t head,
    input  logic      not_empty,
    input  logic      full,
    input  logic      ack,
    input  logic      xfer_stop,
    output logic      wr_en,
    output logic      commit,
    output logic      rollback,
    output logic      push,
    output logic      pop,
    output logic      rd_en,
    output logic      req,
    output logic      writting,
    output logic      unlock,
    output logic      drop
);

    typedef enum logic [1:0] {in_idle, in_hdr, in_data, in_skip} in_state_t;
    typedef enum logic [1:0] {eg_idle, eg_offer, eg_stream, eg_release} eg_state_t;

    in_state_t        in_state;
    eg_state_t        eg_state;
    logic [len_w-1:0] exp_len;  // length announced by the header in flight
    logic [len_w-1:0] cnt;      // payload words stored so far
    logic [len_w-1:0] xcnt;     // payload words taken by the fabric
    logic             sop_word;
    logic             accept;
    logic             in_pkt;
    logic             pay_word;
    logic             room;
    logic             last;
    logic             len_hit;
    logic             cut;

    ////////////////////////////////////////
    // ingress

    assign sop_word = word.vld && word.sop;
    assign accept = hdr_done && hdr_ok && !full; // a full queue counts as no room
    assign in_pkt = (in_state == in_hdr && accept) || in_state == in_data;
    assign pay_word = word.vld && !word.sop && in_pkt;
    assign room = cnt < exp_len; // extra words are never stored
    assign last = pay_word && word.eop;
    assign len_hit = room && (cnt + 1'b1 == exp_len);
    assign cut = sop_word && in_pkt; // new header before the eop of this one

    assign wr_en = in_pkt && room;
    assign commit = last && len_hit;
    assign push = commit;
    assign rollback = (last && !len_hit) || cut;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_state <= in_idle;
            exp_len <= '0;
            cnt <= '0;
            drop <= 1'b0;
        end
        else
        begin
            drop <= (in_state == in_hdr && !accept) || rollback;

            if (sop_word)
            begin
                exp_len <= word.data[len_lsb +: len_w];
                cnt <= '0;
            end
            else if (pay_word && room)
                cnt <= cnt + 1'b1;

            case (in_state)
                in_idle, in_skip:
                    if (sop_word)
                        in_state <= in_hdr;
                    else if (in_state == in_skip && word.vld && word.eop)
                        in_state <= in_idle;
                in_hdr:
                    if (sop_word)
                        in_state <= in_hdr;
                    else if (!accept)
                        in_state <= in_skip; // ignore the rest of this packet
                    else if (last)
                        in_state <= in_idle;
                    else
                        in_state <= in_data;
                in_data:
                    if (sop_word)
                        in_state <= in_hdr;
                    else if (last)
                        in_state <= in_idle;
                default:
                    in_state <= in_idle;
            endcase
        end
    end

    ////////////////////////////////////////
    // egress

    assign req = eg_state == eg_offer || eg_state == eg_stream;
    assign writting = eg_state == eg_stream;
    assign rd_en = writting && !xfer_stop;
    assign unlock = eg_state == eg_release; // req is already low here
    assign pop = unlock;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            eg_state <= eg_idle;
            xcnt <= '0;
        end
        else
        begin
            case (eg_state)
                eg_idle:
                    // the previous handshake must be closed before a new offer
                    if (not_empty && !ack)
                        eg_state <= eg_offer;
                eg_offer:
                    if (ack)
                    begin
                        eg_state <= eg_stream;
                        xcnt <= '0;
                    end
                eg_stream:
                    if (rd_en)
                    begin
                        xcnt <= xcnt + 1'b1;
                        if (xcnt + 1'b1 == head.len)
                            eg_state <= eg_release;
                    end
                eg_release:
                    eg_state <= eg_idle;
                default:
                    eg_state <= eg_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/port_desc_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module port_desc_queue
    import sw_cfg_pkg::*, sw_pkt_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      push,
    input  pkt_desc_t push_desc,
    input  logic      pop,
    output pkt_desc_t head,
    output logic      not_empty,
    output logic      full
);

    pkt_desc_t mem [desc_depth];

    logic [desc_aw-1:0] wr_ptr;
    logic [desc_aw-1:0] rd_ptr;
    logic [desc_aw:0]   count;
    logic               do_push;
    logic               do_pop;

    assign full = count == (desc_aw+1)'(desc_depth);
    assign not_empty = count != '0;
    assign do_push = push && !full;
    assign do_pop = pop && not_empty;

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_desc;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two so it wraps
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (desc_aw+1)'(do_push) - (desc_aw+1)'(do_pop);
        end
    end

    assign head = mem[rd_ptr];

endmodule

`default_nettype wire

/* hw/port_pkt_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module port_pkt_buffer
    import sw_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    sw_word_if.snk            word,
    input  logic              wr_en,
    input  logic              commit,
    input  logic              rollback,
    input  logic              rd_en,
    output logic [word_w-1:0] rd_data,
    output logic [buf_aw:0]   free
);

    logic [word_w-1:0] mem [buf_depth];

    // the top bit of each pointer flags a lap of the ring
    logic [buf_aw:0] spec_ptr; // write position of the packet in flight
    logic [buf_aw:0] cmt_ptr;  // end of the last accepted packet
    logic [buf_aw:0] rd_ptr;
    logic [buf_aw:0] spec_nxt;
    logic            wr_fire;

    assign wr_fire = wr_en && word.vld && !word.sop;
    assign spec_nxt = spec_ptr + (buf_aw+1)'(wr_fire);

    ////////////////////////////////////////
    // storage

    always_ff @(posedge clk)
    begin
        if (wr_fire)
            mem[spec_ptr[buf_aw-1:0]] <= word.data;
    end

    assign rd_data = mem[rd_ptr[buf_aw-1:0]]; // egress sees the head word at once

    ////////////////////////////////////////
    // pointers

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            spec_ptr <= '0;
            cmt_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            // a rollback also discards a word written in the same cycle
            if (rollback)
                spec_ptr <= cmt_ptr;
            else
                spec_ptr <= spec_nxt;

            if (commit)
                cmt_ptr <= spec_nxt; // the eop word lands with the commit
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // fill is measured from the speculative pointer
    assign free = (buf_aw+1)'(buf_depth) - (spec_ptr - rd_ptr);

endmodule

`default_nettype wire

/* hw/port_hdr_parse.sv */
`timescale 1ns/1ps
`default_nettype none

module port_hdr_parse
    import sw_cfg_pkg::*, sw_pkt_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    sw_word_if.snk        word,
    input  logic [buf_aw:0] buf_free,
    output logic          hdr_done,
    output logic          hdr_ok,
    output pkt_desc_t     desc
);

    logic             sop_word;
    logic [len_w-1:0] hdr_len;

    assign sop_word = word.vld && word.sop;
    assign hdr_len = word.data[len_lsb +: len_w];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hdr_done <= 1'b0;
            hdr_ok <= 1'b0;
        end
        else
        begin
            hdr_done <= sop_word;
            if (sop_word)
                hdr_ok <= (hdr_len != '0) && (hdr_len <= len_w'(max_len))
                          && (hdr_len <= len_w'(buf_free)); // room counts claimed space
        end
    end

    always_ff @(posedge clk)
    begin
        if (sop_word)
        begin
            desc.len <= hdr_len;
            desc.prio <= word.data[prio_lsb +: prio_w];
            desc.dest <= word.data[dest_lsb +: dest_w];
        end
    end

endmodule

`default_nettype wire

/* hw/sw_word_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sw_word_if
    import sw_cfg_pkg::*;
();

    logic              sop;  // header word
    logic              eop;  // last payload word
    logic              vld;
    logic [word_w-1:0] data;

    // driven from the port inputs
    modport src
    (
        output sop, eop, vld, data
    );

    // all ingress blocks only observe the stream
    modport snk
    (
        input sop, eop, vld, data
    );

endinterface

`default_nettype wire

/* hw/sw_pkt_pkg.sv */
`default_nettype none

package sw_pkt_pkg;

    // header field widths
    localparam int len_w = 9;
    localparam int prio_w = 3;
    localparam int dest_w = 4;

    // bit positions inside the header word
    localparam int len_lsb = 7;
    localparam int prio_lsb = 4;
    localparam int dest_lsb = 0;

    ////////////////////////////////////////
    // descriptor of one buffered packet

    // field order follows the header word, so the struct is a copy of it
    typedef struct packed
    {
        logic [len_w-1:0]  len;
        logic [prio_w-1:0] prio;
        logic [dest_w-1:0] dest;
    } pkt_desc_t;

endpackage

`default_nettype wire

/* hw/sw_cfg_pkg.sv */
`default_nettype none

package sw_cfg_pkg;

    // stream word and payload limits
    localparam int word_w = 16;
    localparam int max_len = 64; // largest legal payload in words

    ////////////////////////////////////////
    // payload buffer
    localparam int buf_depth = 128;
    localparam int buf_aw = 7; // pointers carry one more bit for wrap

    ////////////////////////////////////////
    // descriptor queue
    localparam int desc_depth = 4;
    localparam int desc_aw = $clog2(desc_depth);

endpackage

`default_nettype wire
